// File: rtl/rrvCtrlPkg.sv
//------------------------------------------------
// Shared types of the RV32I pipeline control unit
// Widths, opcode, ALU-op, write-back, immediate and branch enums
// Instruction word union with field and immediate views
// Control word and the per-stage output structs
//------------------------------------------------
package rrvCtrlPkg;

    localparam int XLen     = 32;
    localparam int RegAddrW = 5;
    localparam logic [XLen-1:0] NopInst = 32'h0000_0013; // ADDI x0,x0,0

    // RV32I major opcodes
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011,
        FENCE  = 7'b0001111,
        SYSCAL = 7'b1110011
    } opcodeT;

    typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} aluOpT;
    typedef enum logic [1:0] {WbAlu, WbDMem, WbPc4} wbSelT;
    typedef enum logic [2:0] {ImmI, ImmS, ImmB, ImmU, ImmJ} immTypeT;

    // Straight from funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branchOpT;

    // ------------------------------------------------
    // Instruction word, two views of the same 32 bits
    // ------------------------------------------------
    typedef struct packed {
        logic [6:0]          funct7;
        logic [RegAddrW-1:0] rs2;
        logic [RegAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [RegAddrW-1:0] rd;
        opcodeT              opcode;
    } instFieldsT;

    typedef struct packed {
        logic [11:0] hi;     // Bits 31:20
        logic [7:0]  mid;    // Bits 19:12
        logic [4:0]  low;    // Bits 11:7, rd slot
        opcodeT      opcode;
    } instImmT;

    typedef union packed {
        instFieldsT fields;
        instImmT    imm;
    } instWordT;

    // ------------------------------------------------
    // Control word carried down the pipe
    // ------------------------------------------------
    typedef struct packed {
        logic [XLen-1:0]     pc;
        instWordT            instruction;
        opcodeT              opcode;
        aluOpT               aluOp;
        logic                lui;
        logic                selAluPc;
        logic                selAluImm;
        logic                selNextPcJ;   // JAL / JALR
        logic                selNextPcB;   // Conditional branch
        logic                regWrEn;
        logic                dMemWrEn;
        logic                dMemRdEn;
        logic [3:0]          dMemByteEn;
        logic                signExt;
        wbSelT               wbSel;
        branchOpT            branchOp;
        logic [RegAddrW-1:0] regDst;
        logic [RegAddrW-1:0] regSrc1;
        logic [RegAddrW-1:0] regSrc2;
    } ctrlWordT;

    typedef struct packed {
        logic [RegAddrW-1:0] regSrc1Q102;
        logic [RegAddrW-1:0] regSrc2Q102;
        aluOpT               aluOpQ102;
        logic                luiQ102;
        branchOpT            branchOpQ102;
        logic                selAluPcQ102;
        logic                selAluImmQ102;
        logic [RegAddrW-1:0] regDstQ103;
        logic                regWrEnQ103;
        logic [RegAddrW-1:0] regDstQ104;
        logic                regWrEnQ104;
        logic [RegAddrW-1:0] regDstQ105;
        logic                regWrEnQ105;
    } ctrlExeT;

    typedef struct packed {
        logic       dMemWrEnQ103;
        logic       dMemRdEnQ103;
        logic [3:0] dMemByteEnQ103;
    } ctrlMemT;

    typedef struct packed {
        logic [3:0]          byteEnQ105;
        logic                signExtQ105;
        wbSelT               wbSelQ105;
        logic [RegAddrW-1:0] regDstQ105;
        logic                regWrEnQ105;  // Qualified by Q105 valid
    } ctrlWbT;

    typedef struct packed {
        logic [RegAddrW-1:0] regSrc1Q101;
        logic [RegAddrW-1:0] regSrc2Q101;
    } ctrlRfT;

endpackage

// File: rtl/instDecoder.sv
//------------------------------------------------
// Q101 instruction decoder
// Opcode to selects, memory enables and write-back path
// funct3 / funct7 to ALU op, byte lanes and sign extension
//------------------------------------------------
module instDecoder (
    input  rrvCtrlPkg::instWordT        inst,
    input  logic [rrvCtrlPkg::XLen-1:0] pc,
    output rrvCtrlPkg::ctrlWordT        ctrlQ101
);
    import rrvCtrlPkg::*;

    opcodeT     op;
    logic [2:0] funct3;
    logic       altFunct;   // funct7[5], picks SUB / SRA
    logic       isJump;
    logic       isMem;

    assign op       = inst.fields.opcode;
    assign funct3   = inst.fields.funct3;
    assign altFunct = inst.fields.funct7[5];
    assign isJump   = (op == JAL) || (op == JALR);
    assign isMem    = (op == LOAD) || (op == STORE);

    always_comb begin
        ctrlQ101             = '0;
        ctrlQ101.pc          = pc;
        ctrlQ101.instruction = inst;
        ctrlQ101.opcode      = op;
        ctrlQ101.lui         = (op == LUI);
        ctrlQ101.selAluPc    = (op == JAL) || (op == BRANCH) || (op == AUIPC);
        ctrlQ101.selAluImm   = (op != R_OP);   // Only reg-reg uses rs2
        ctrlQ101.selNextPcJ  = isJump;
        ctrlQ101.selNextPcB  = (op == BRANCH);
        ctrlQ101.regWrEn     = isJump || (op inside {LUI, AUIPC, LOAD, I_OP, R_OP, FENCE});
        ctrlQ101.dMemWrEn    = (op == STORE);
        ctrlQ101.dMemRdEn    = (op == LOAD);
        ctrlQ101.signExt     = (op == LOAD) && !funct3[2]; // LB / LH
        ctrlQ101.wbSel       = isJump ? WbPc4 : (op == LOAD) ? WbDMem : WbAlu;
        ctrlQ101.branchOp    = branchOpT'(funct3);
        ctrlQ101.regDst      = inst.fields.rd;
        ctrlQ101.regSrc1     = inst.fields.rs1;
        ctrlQ101.regSrc2     = inst.fields.rs2;

        // Byte lanes from the size bits
        if (isMem) begin
            case (funct3[1:0])
                2'b00:   ctrlQ101.dMemByteEn = 4'b0001;  // Byte
                2'b01:   ctrlQ101.dMemByteEn = 4'b0011;  // Half
                2'b10:   ctrlQ101.dMemByteEn = 4'b1111;  // Word
                default: ctrlQ101.dMemByteEn = 4'b0000;
            endcase
        end

        // ALU op, address forms and the rest fall back to ADD
        ctrlQ101.aluOp = ADD;
        if ((op == R_OP) || (op == I_OP)) begin
            case (funct3)
                3'b000:  ctrlQ101.aluOp = ((op == R_OP) && altFunct) ? SUB : ADD;
                3'b001:  ctrlQ101.aluOp = SLL;
                3'b010:  ctrlQ101.aluOp = SLT;
                3'b011:  ctrlQ101.aluOp = SLTU;
                3'b100:  ctrlQ101.aluOp = XOR;
                3'b101:  ctrlQ101.aluOp = altFunct ? SRA : SRL;  // Also SRAI / SRLI
                3'b110:  ctrlQ101.aluOp = OR;
                default: ctrlQ101.aluOp = AND;
            endcase
        end
    end

endmodule

// File: rtl/immGen.sv
//------------------------------------------------
// Immediate generator
// Format select from the opcode, then I/S/B/U/J assembly
//------------------------------------------------
module immGen (
    input  rrvCtrlPkg::instWordT        inst,
    output logic [rrvCtrlPkg::XLen-1:0] immediate
);
    import rrvCtrlPkg::*;

    immTypeT immType;
    instImmT iv;        // Immediate view of the word

    assign iv = inst.imm;

    always_comb begin
        case (iv.opcode)
            LUI, AUIPC: immType = ImmU;
            JAL:        immType = ImmJ;
            BRANCH:     immType = ImmB;
            STORE:      immType = ImmS;
            default:    immType = ImmI;  // JALR, I_OP, LOAD, unknown
        endcase
    end

    // Sign always from bit 31
    always_comb begin
        case (immType)
            ImmS:    immediate = {{20{iv.hi[11]}}, iv.hi[11:5], iv.low};
            ImmB:    immediate = {{20{iv.hi[11]}}, iv.low[0], iv.hi[10:5], iv.low[4:1], 1'b0};
            ImmU:    immediate = {iv.hi, iv.mid, 12'b0};
            ImmJ:    immediate = {{12{iv.hi[11]}}, iv.mid, iv.hi[0], iv.hi[10:1], 1'b0};
            default: immediate = {{20{iv.hi[11]}}, iv.hi};
        endcase
    end

endmodule

// File: rtl/hazardUnit.sv
//------------------------------------------------
// Load-use hazard detection against Q102 and Q103
// NOP insertion request and all stage-ready signals
//------------------------------------------------
module hazardUnit (
    input  rrvCtrlPkg::instWordT rawInst,
    input  rrvCtrlPkg::ctrlWordT ctrlQ102,
    input  rrvCtrlPkg::ctrlWordT ctrlQ103,
    input  logic                 validQ102,
    input  logic                 validQ103,
    input  logic                 flushActive,
    input  logic                 dMemReady,
    output logic                 insertNop,
    output logic                 readyQ100,
    output logic                 readyQ101,
    output logic [3:0]           stageReady   // Q102..Q105
);
    import rrvCtrlPkg::*;

    logic useRs2;
    logic hzdQ102;
    logic hzdQ103;
    logic loadHazard;

    // A valid LOAD whose rd feeds a source of the raw word
    function automatic logic loadMatch(input ctrlWordT ctrl, input logic valid,
                                       input instWordT raw, input logic chkRs2);
        logic rs1Hit;
        logic rs2Hit;
        rs1Hit = (raw.fields.rs1 == ctrl.regDst);
        rs2Hit = chkRs2 && (raw.fields.rs2 == ctrl.regDst);
        return valid && (ctrl.opcode == LOAD) && (rs1Hit || rs2Hit);
    endfunction

    assign useRs2 = rawInst.fields.opcode inside {R_OP, STORE, BRANCH}; // rs2 really read

    assign hzdQ102    = loadMatch(ctrlQ102, validQ102, rawInst, useRs2);
    assign hzdQ103    = loadMatch(ctrlQ103, validQ103, rawInst, useRs2);
    assign loadHazard = hzdQ102 || hzdQ103;

    assign insertNop = loadHazard || flushActive;   // Bubble into Q101

    // ------------------------------------------------
    // Back-pressure
    // ------------------------------------------------
    assign stageReady = {4{dMemReady}};                                // Freeze on data memory
    assign readyQ101  = (dMemReady && !loadHazard) || flushActive;     // Flush slot always taken
    assign readyQ100  = dMemReady && readyQ101;

endmodule

// File: rtl/flushTimer.sv
//------------------------------------------------
// Flush window counter
// Holds the Q101 bubble window open after a Q102 redirect
//------------------------------------------------
module flushTimer #(
    parameter int FlushCycles = 2
) (
    input  logic Clock,
    input  logic rstN,
    input  logic redirect,
    input  logic advance,
    output logic flushActive
);

    localparam int CntW = $clog2(FlushCycles + 1);

    logic [CntW-1:0] count;  // Slots left after the current one

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            count <= '0;
        end else if (redirect) begin
            count <= CntW'(FlushCycles - 1);  // Redirect cycle is slot one
        end else if (advance && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    assign flushActive = redirect || (count != '0);

endmodule

// File: rtl/ctrlPipe.sv
//------------------------------------------------
// Control word and valid bit stage registers Q102..Q105
// Q102 redirect and the per-stage output structs
//------------------------------------------------
module ctrlPipe (
    input  logic                 Clock,
    input  logic                 rstN,
    input  rrvCtrlPkg::ctrlWordT ctrlQ101,
    input  logic                 validQ101,
    input  logic [3:0]           stageReady,
    input  logic                 branchCondMetQ102,
    output rrvCtrlPkg::ctrlWordT ctrlQ102,
    output rrvCtrlPkg::ctrlWordT ctrlQ103,
    output logic                 validQ102,
    output logic                 validQ103,
    output logic                 redirect,
    output rrvCtrlPkg::ctrlRfT   ctrlRf,
    output rrvCtrlPkg::ctrlExeT  ctrlExe,
    output rrvCtrlPkg::ctrlMemT  ctrlMem,
    output rrvCtrlPkg::ctrlWbT   ctrlWb,
    output logic                 validInstQ105
);
    import rrvCtrlPkg::*;

    ctrlWordT   ctrlQ [2:5];
    logic [5:2] preValid;   // Captured valid, before the stage ready gate
    logic [5:1] valid;

    assign valid[1] = validQ101;

    // ------------------------------------------------
    // One enable register per stage
    // ------------------------------------------------
    for (genvar s = 2; s <= 5; s++) begin : gStage
        ctrlWordT prevCtrl;

        if (s == 2) begin : gFirst
            assign prevCtrl = ctrlQ101;
        end else begin : gNext
            assign prevCtrl = ctrlQ[s-1];
        end

        always_ff @(posedge Clock) begin
            if (!rstN) begin
                ctrlQ[s]    <= '0;
                preValid[s] <= 1'b0;
            end else if (stageReady[s-2]) begin  // Hold while frozen
                ctrlQ[s]    <= prevCtrl;
                preValid[s] <= valid[s-1];
            end
        end

        assign valid[s] = stageReady[s-2] && preValid[s];
    end

    assign ctrlQ102      = ctrlQ[2];
    assign ctrlQ103      = ctrlQ[3];
    assign validQ102     = valid[2];
    assign validQ103     = valid[3];
    assign validInstQ105 = valid[5];

    // Jump, or branch with its condition met
    assign redirect = valid[2] && (ctrlQ[2].selNextPcJ ||
                                   (ctrlQ[2].selNextPcB && branchCondMetQ102));

    // ------------------------------------------------
    // Per-stage outputs
    // ------------------------------------------------
    assign ctrlRf = '{regSrc1Q101: ctrlQ101.regSrc1, regSrc2Q101: ctrlQ101.regSrc2};

    assign ctrlExe = '{
        regSrc1Q102:   ctrlQ[2].regSrc1,
        regSrc2Q102:   ctrlQ[2].regSrc2,
        aluOpQ102:     ctrlQ[2].aluOp,
        luiQ102:       ctrlQ[2].lui,
        branchOpQ102:  ctrlQ[2].branchOp,
        selAluPcQ102:  ctrlQ[2].selAluPc,
        selAluImmQ102: ctrlQ[2].selAluImm,
        regDstQ103:    ctrlQ[3].regDst,
        regWrEnQ103:   ctrlQ[3].regWrEn,
        regDstQ104:    ctrlQ[4].regDst,
        regWrEnQ104:   ctrlQ[4].regWrEn,
        regDstQ105:    ctrlQ[5].regDst,
        regWrEnQ105:   ctrlQ[5].regWrEn
    };

    assign ctrlMem = '{dMemWrEnQ103:   ctrlQ[3].dMemWrEn,
                       dMemRdEnQ103:   ctrlQ[3].dMemRdEn,
                       dMemByteEnQ103: ctrlQ[3].dMemByteEn};

    assign ctrlWb = '{byteEnQ105:  ctrlQ[5].dMemByteEn,
                      signExtQ105: ctrlQ[5].signExt,
                      wbSelQ105:   ctrlQ[5].wbSel,
                      regDstQ105:  ctrlQ[5].regDst,
                      regWrEnQ105: valid[5] && ctrlQ[5].regWrEn};  // No write from bubbles

endmodule

// File: rtl/coreCtrl.sv
//------------------------------------------------
// Control unit top of the five-stage RV32I pipe
// Decoder, immediate generator, hazard unit, flush counter
// and the control pipe
//------------------------------------------------
module coreCtrl #(
    parameter int FlushCycles = 2
) (
    input  logic                        Clock,
    input  logic                        rstN,
    input  rrvCtrlPkg::instWordT        instQ101,
    input  logic [rrvCtrlPkg::XLen-1:0] pcQ101,
    input  logic                        branchCondMetQ102,
    input  logic                        dMemReady,
    output logic                        readyQ100,
    output logic                        readyQ101,
    output logic [3:0]                  stageReady,
    output logic                        selNextPcAluOutQ102,
    output logic [rrvCtrlPkg::XLen-1:0] immediateQ101,
    output rrvCtrlPkg::ctrlRfT          ctrlRf,
    output rrvCtrlPkg::ctrlExeT         ctrlExe,
    output rrvCtrlPkg::ctrlMemT         ctrlMem,
    output rrvCtrlPkg::ctrlWbT          ctrlWb,
    output logic                        validInstQ105
);
    import rrvCtrlPkg::*;

    instWordT instDec;   // Word after NOP insertion
    ctrlWordT ctrlQ101;
    ctrlWordT ctrlQ102;
    ctrlWordT ctrlQ103;
    logic     insertNop;
    logic     flushActive;
    logic     validQ101;
    logic     validQ102;
    logic     validQ103;

    assign instDec   = insertNop ? instWordT'(NopInst) : instQ101;
    assign validQ101 = readyQ101 && !insertNop;

    instDecoder uDecoder (.inst(instDec), .pc(pcQ101), .ctrlQ101(ctrlQ101));

    immGen uImmGen (.inst(instDec), .immediate(immediateQ101));

    hazardUnit uHazard (
        .rawInst    (instQ101),
        .ctrlQ102   (ctrlQ102),
        .ctrlQ103   (ctrlQ103),
        .validQ102  (validQ102),
        .validQ103  (validQ103),
        .flushActive(flushActive),
        .dMemReady  (dMemReady),
        .insertNop  (insertNop),
        .readyQ100  (readyQ100),
        .readyQ101  (readyQ101),
        .stageReady (stageReady)
    );

    flushTimer #(.FlushCycles(FlushCycles)) uFlush (
        .Clock      (Clock),
        .rstN       (rstN),
        .redirect   (selNextPcAluOutQ102),
        .advance    (stageReady[0]),      // Slot moves into Q102
        .flushActive(flushActive)
    );

    ctrlPipe uPipe (
        .Clock            (Clock),
        .rstN             (rstN),
        .ctrlQ101         (ctrlQ101),
        .validQ101        (validQ101),
        .stageReady       (stageReady),
        .branchCondMetQ102(branchCondMetQ102),
        .ctrlQ102         (ctrlQ102),
        .ctrlQ103         (ctrlQ103),
        .validQ102        (validQ102),
        .validQ103        (validQ103),
        .redirect         (selNextPcAluOutQ102),
        .ctrlRf           (ctrlRf),
        .ctrlExe          (ctrlExe),
        .ctrlMem          (ctrlMem),
        .ctrlWb           (ctrlWb),
        .validInstQ105    (validInstQ105)
    );

endmodule

// File: include/ctrlModel.svh
//------------------------------------------------
// Testbench reference model of the control unit
// Expected control word, expected immediate and load-use rule
// Written on raw bit slices, apart from the DUT's union views
//------------------------------------------------
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

function automatic ctrlWordT modelDecode(input logic [31:0] inst, input logic [31:0] pc);
    ctrlWordT   c;
    logic [6:0] op;
    logic [2:0] f3;
    op = inst[6:0];
    f3 = inst[14:12];
    c = '0;
    c.pc          = pc;
    c.instruction = inst;
    c.opcode      = opcodeT'(op);
    c.lui         = (op == LUI);
    c.selAluPc    = op inside {JAL, BRANCH, AUIPC};
    c.selAluImm   = (op != R_OP);
    c.selNextPcJ  = op inside {JAL, JALR};
    c.selNextPcB  = (op == BRANCH);
    c.regWrEn     = op inside {LUI, AUIPC, JAL, JALR, LOAD, I_OP, R_OP, FENCE};
    c.dMemWrEn    = (op == STORE);
    c.dMemRdEn    = (op == LOAD);
    c.signExt     = (op == LOAD) && !f3[2];
    c.wbSel       = (op inside {JAL, JALR}) ? WbPc4 : (op == LOAD) ? WbDMem : WbAlu;
    c.branchOp    = branchOpT'(f3);
    c.regDst      = inst[11:7];
    c.regSrc1     = inst[19:15];
    c.regSrc2     = inst[24:20];
    if ((op inside {LOAD, STORE}) && (f3[1:0] != 2'b11)) begin
        c.dMemByteEn = (f3[1:0] == 2'b00) ? 4'b0001 : (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
    end
    if (op inside {R_OP, I_OP}) begin
        case (f3)
            3'd0:    c.aluOp = ((op == R_OP) && inst[30]) ? SUB : ADD;
            3'd1:    c.aluOp = SLL;
            3'd2:    c.aluOp = SLT;
            3'd3:    c.aluOp = SLTU;
            3'd4:    c.aluOp = XOR;
            3'd5:    c.aluOp = inst[30] ? SRA : SRL;
            3'd6:    c.aluOp = OR;
            default: c.aluOp = AND;
        endcase
    end
    return c;
endfunction

function automatic logic [31:0] modelImm(input logic [31:0] inst);
    case (inst[6:0])
        LUI, AUIPC: return {inst[31:12], 12'b0};
        JAL:        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        BRANCH:     return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        STORE:      return {{20{inst[31]}}, inst[31:25], inst[11:7]};
        default:    return {{20{inst[31]}}, inst[31:20]};
    endcase
endfunction

// Stall when a valid LOAD ahead writes a register the new word reads
function automatic bit modelLoadHazard(input logic [31:0] raw,
                                       input ctrlWordT q2, input bit v2,
                                       input ctrlWordT q3, input bit v3);
    bit useRs2;
    bit hit2;
    bit hit3;
    useRs2 = raw[6:0] inside {R_OP, STORE, BRANCH};
    hit2 = v2 && (q2.opcode == LOAD) &&
           ((raw[19:15] == q2.regDst) || (useRs2 && (raw[24:20] == q2.regDst)));
    hit3 = v3 && (q3.opcode == LOAD) &&
           ((raw[19:15] == q3.regDst) || (useRs2 && (raw[24:20] == q3.regDst)));
    return hit2 || hit3;
endfunction

`endif

// File: test/coreCtrlTb.sv
//------------------------------------------------
// Testbench of the RV32I pipeline control unit
// Clock, reset, LFSR-driven instruction stream
// Shadow pipeline queue built on the reference model
// Compare tasks per result type, watchdog
//------------------------------------------------
module coreCtrlTb;
    timeunit 1ns;
    timeprecision 100ps;

    import rrvCtrlPkg::*;
    `include "ctrlModel.svh"

    localparam int          FlushCycles = 2;
    localparam int          ClkPeriod   = 10;
    localparam int          ResetCycles = 4;
    localparam int          NumCycles   = 3000;
    localparam int          WatchdogNs  = (NumCycles + ResetCycles) * ClkPeriod * 2;
    localparam logic [15:0] Seed        = 16'd61372;

    // One model stage: control word and captured valid bit
    typedef struct packed {
        ctrlWordT c;
        logic     v;
    } slotT;

    logic            Clock = 1'b0;
    logic            rstN;
    instWordT        instQ101;
    logic [XLen-1:0] pcQ101;
    logic            branchCondMetQ102;
    logic            dMemReady;
    logic            readyQ100;
    logic            readyQ101;
    logic [3:0]      stageReady;
    logic            selNextPcAluOutQ102;
    logic [XLen-1:0] immediateQ101;
    ctrlRfT          ctrlRf;
    ctrlExeT         ctrlExe;
    ctrlMemT         ctrlMem;
    ctrlWbT          ctrlWb;
    logic            validInstQ105;

    logic [15:0] lfsr;
    slotT        pipeQ[$];      // Index 0 is Q102, index 3 is Q105
    int          slotsLeft;     // Flush slots left after the current one
    bit          fetchNext;     // Fetch moved on at the last edge
    int          stallCount;
    int          redirectCount;
    int          freezeCount;

    coreCtrl #(.FlushCycles(FlushCycles)) dut (.*);

    always #(ClkPeriod / 2) Clock = ~Clock;

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Weighted RV32I mix, registers limited to x0..x3
    function automatic logic [31:0] randomInst();
        logic [31:0] w;
        logic [3:0]  sel;
        logic [2:0]  f3;
        logic        alt;
        w        = takeBits(32);
        sel      = 4'(takeBits(4));
        f3       = 3'(takeBits(3));
        alt      = 1'(takeBits(1));
        w[11:7]  = 5'(takeBits(2));   // rd
        w[19:15] = 5'(takeBits(2));   // rs1
        if (sel <= 4'd3) begin
            w[6:0]   = R_OP;
            w[14:12] = f3;
            w[24:20] = 5'(takeBits(2));
            w[31:25] = (alt && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
        end else if (sel <= 4'd6) begin
            w[6:0]   = I_OP;
            w[14:12] = f3;
            if (f3 == 3'd1) begin
                w[31:25] = 7'h00;                     // SLLI
            end else if (f3 == 3'd5) begin
                w[31:25] = alt ? 7'h20 : 7'h00;       // SRAI or SRLI
            end
        end else if (sel <= 4'd9) begin
            w[6:0]   = LOAD;
            w[14:12] = (f3 inside {3'd3, 3'd6, 3'd7}) ? 3'd2 : f3;
        end else if (sel <= 4'd11) begin
            w[6:0]   = STORE;
            w[14:12] = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
            w[24:20] = 5'(takeBits(2));
        end else if (sel == 4'd12) begin
            w[6:0]   = BRANCH;
            w[14:12] = (f3[2:1] == 2'b01) ? 3'd0 : f3;
            w[24:20] = 5'(takeBits(2));
        end else if (sel == 4'd13) begin
            w[6:0] = JAL;
        end else if (sel == 4'd14) begin
            w[6:0]   = JALR;
            w[14:12] = 3'd0;
        end else begin
            w[6:0] = alt ? LUI : AUIPC;
        end
        return w;
    endfunction

    task automatic driveInputs();
        if (fetchNext) begin                          // Fetch holds on a stall
            instQ101 = randomInst();
            pcQ101   = pcQ101 + 32'd4;
        end
        branchCondMetQ102 = 1'(takeBits(1));
        dMemReady         = (takeBits(3) != 32'd0);   // Low about 1 in 8
    endtask

    // ------------------------------------------------
    // Compare tasks
    // ------------------------------------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkCtrlWb(input string name, input ctrlWbT act, input ctrlWbT exp);
        if (act !== exp) begin
            failRun($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic checkCtrlMem(input string name, input ctrlMemT act, input ctrlMemT exp);
        if (act !== exp) begin
            failRun($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic checkCtrlExe(input string name, input ctrlExeT act, input ctrlExeT exp);
        if (act !== exp) begin
            failRun($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic checkCtrlRf(input string name, input ctrlRfT act, input ctrlRfT exp);
        if (act !== exp) begin
            failRun($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic checkImm(input string name, input logic [XLen-1:0] act,
                            input logic [XLen-1:0] exp);
        if (act !== exp) begin
            failRun($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic checkBit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            failRun($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    // ------------------------------------------------
    // Model step, sampled mid-cycle
    // ------------------------------------------------
    task automatic checkAndAdvance();
        slotT        s2;
        slotT        s3;
        slotT        s4;
        slotT        s5;
        slotT        nextSlot;
        logic        v2;
        logic        v3;
        logic        v5;
        logic        mRedirect;
        logic        mFlush;
        logic        mHazard;
        logic        mNop;
        logic        mReady101;
        logic        mReady100;
        logic [31:0] rawWord;
        logic [31:0] usedWord;
        ctrlWordT    expCtrl;
        ctrlRfT      expRf;
        ctrlExeT     expExe;
        ctrlMemT     expMem;
        ctrlWbT      expWb;
        s2 = pipeQ[0];
        s3 = pipeQ[1];
        s4 = pipeQ[2];
        s5 = pipeQ[3];
        v2 = s2.v && dMemReady;      // Valid gated by stage ready
        v3 = s3.v && dMemReady;
        v5 = s5.v && dMemReady;

        mRedirect = v2 && (s2.c.selNextPcJ || (s2.c.selNextPcB && branchCondMetQ102));
        mFlush    = mRedirect || (slotsLeft != 0);
        rawWord   = instQ101;
        mHazard   = modelLoadHazard(rawWord, s2.c, v2, s3.c, v3);
        mNop      = mHazard || mFlush;
        mReady101 = (dMemReady && !mHazard) || mFlush;
        mReady100 = dMemReady && mReady101;
        usedWord  = mNop ? NopInst : rawWord;
        expCtrl   = modelDecode(usedWord, pcQ101);

        expRf.regSrc1Q101    = expCtrl.regSrc1;
        expRf.regSrc2Q101    = expCtrl.regSrc2;
        expExe.regSrc1Q102    = s2.c.regSrc1;
        expExe.regSrc2Q102    = s2.c.regSrc2;
        expExe.aluOpQ102      = s2.c.aluOp;
        expExe.luiQ102        = s2.c.lui;
        expExe.branchOpQ102   = s2.c.branchOp;
        expExe.selAluPcQ102   = s2.c.selAluPc;
        expExe.selAluImmQ102  = s2.c.selAluImm;
        expExe.regDstQ103     = s3.c.regDst;
        expExe.regWrEnQ103    = s3.c.regWrEn;
        expExe.regDstQ104     = s4.c.regDst;
        expExe.regWrEnQ104    = s4.c.regWrEn;
        expExe.regDstQ105     = s5.c.regDst;
        expExe.regWrEnQ105    = s5.c.regWrEn;
        expMem.dMemWrEnQ103   = s3.c.dMemWrEn;
        expMem.dMemRdEnQ103   = s3.c.dMemRdEn;
        expMem.dMemByteEnQ103 = s3.c.dMemByteEn;
        expWb.byteEnQ105      = s5.c.dMemByteEn;
        expWb.signExtQ105     = s5.c.signExt;
        expWb.wbSelQ105       = s5.c.wbSel;
        expWb.regDstQ105      = s5.c.regDst;
        expWb.regWrEnQ105     = v5 && s5.c.regWrEn;

        checkBit("readyQ101", readyQ101, mReady101);
        checkBit("readyQ100", readyQ100, mReady100);
        for (int k = 0; k < 4; k++) begin
            checkBit($sformatf("stageReady[%0d]", k), stageReady[k], dMemReady);
        end
        checkBit("selNextPcAluOutQ102", selNextPcAluOutQ102, mRedirect);
        checkImm("immediateQ101", immediateQ101, modelImm(usedWord));
        checkCtrlRf("ctrlRf", ctrlRf, expRf);
        checkCtrlExe("ctrlExe", ctrlExe, expExe);
        checkCtrlMem("ctrlMem", ctrlMem, expMem);
        checkCtrlWb("ctrlWb", ctrlWb, expWb);
        checkBit("validInstQ105", validInstQ105, v5);

        // Whole pipe moves only with data memory ready
        if (dMemReady) begin
            nextSlot.c = expCtrl;
            nextSlot.v = mReady101 && !mNop;
            pipeQ.push_front(nextSlot);
            void'(pipeQ.pop_back());
        end
        if (mRedirect) begin
            slotsLeft = FlushCycles - 1;             // Current slot is the first
        end else if (dMemReady && (slotsLeft != 0)) begin
            slotsLeft--;
        end
        fetchNext = mReady100;

        if (!dMemReady) begin
            freezeCount++;
        end
        if (mHazard && dMemReady && !mFlush) begin
            stallCount++;
        end
        if (mRedirect) begin
            redirectCount++;
        end
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        slotT empty;
        empty             = '0;
        lfsr              = Seed;
        rstN              = 1'b0;
        instQ101          = NopInst;
        pcQ101            = '0;
        branchCondMetQ102 = 1'b0;
        dMemReady         = 1'b1;
        slotsLeft         = 0;
        fetchNext         = 1'b1;
        stallCount        = 0;
        redirectCount     = 0;
        freezeCount       = 0;
        for (int k = 0; k < 4; k++) begin
            pipeQ.push_back(empty);
        end

        repeat (ResetCycles) @(posedge Clock);
        #1 rstN = 1'b1;
        @(negedge Clock);
        checkBit("flushActive", dut.flushActive, 1'b0);   // Clean state out of reset
        checkAndAdvance();

        for (int cyc = 0; cyc < NumCycles; cyc++) begin
            @(posedge Clock);
            #1 driveInputs();
            @(negedge Clock);
            checkAndAdvance();
        end

        if ((stallCount == 0) || (redirectCount == 0) || (freezeCount == 0)) begin
            failRun("Random stream never produced a stall, a redirect and a freeze");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    // Hang guard
    initial begin
        #(WatchdogNs);
        failRun("Watchdog expired before the test sequence finished");
    end

endmodule

// File: filelist.f
+incdir+include
rtl/rrvCtrlPkg.sv
rtl/instDecoder.sv
rtl/immGen.sv
rtl/hazardUnit.sv
rtl/flushTimer.sv
rtl/ctrlPipe.sv
rtl/coreCtrl.sv
test/coreCtrlTb.sv

// File: Makefile
# Verilator simulation of the control unit testbench

VERILATOR ?= verilator
TOP       ?= coreCtrlTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
